// ==== logic/fpu_consts.svh ====
`ifndef FPU_CONSTS_SVH
`define FPU_CONSTS_SVH

// Thread lanes per request
`define FPU_NUM_THREADS 2

`define FPU_NUM_WARPS 4
`define FPU_NW_BITS 2

// Register file index width
`define FPU_NR_BITS 5

// Request slots, matches the issuer's initial credits
`define FPU_QUEUE_SIZE 4
`define FPU_QUEUE_BITS 2

// Commits the consumer can absorb before returning a credit
`define FPU_COMMIT_CREDITS 2

`endif

// ==== logic/fpu_pkg.sv ====
`include "fpu_consts.svh"

package fpu_pkg;

    typedef enum logic [3:0] {
        FPU_SGNJ  = 4'd0,
        FPU_SGNJN = 4'd1,
        FPU_SGNJX = 4'd2,
        FPU_MIN   = 4'd3,
        FPU_MAX   = 4'd4,
        FPU_EQ    = 4'd5,
        FPU_LT    = 4'd6,
        FPU_LE    = 4'd7,
        FPU_CLASS = 4'd8
    } fpu_op_e;

    // Same bit order as the RISC-V fflags CSR
    typedef struct packed {
        logic nv;
        logic dz;
        logic of;
        logic uf;
        logic nx;
    } fflags_t;

    typedef struct packed {
        logic        sign;
        logic [7:0]  exp;
        logic [22:0] frac;
    } float_fields_t;

    // Raw word for sign injection and pass-through, fields for decoding
    typedef union packed {
        logic [31:0]   raw;
        float_fields_t f;
    } float_word_u;

    typedef struct packed {
        logic [`FPU_NW_BITS-1:0]     wid;
        logic [`FPU_NUM_THREADS-1:0] tmask;
        logic [31:0]                 pc;
        logic [`FPU_NR_BITS-1:0]     rd;
        logic                        wb;
    } fpu_meta_t;

    typedef struct packed {
        logic                                     valid;
        fpu_op_e                                  op;
        fpu_meta_t                                meta;
        float_word_u [`FPU_NUM_THREADS-1:0]       a;
        float_word_u [`FPU_NUM_THREADS-1:0]       b;
        float_word_u [`FPU_NUM_THREADS-1:0]       c;
    } fpu_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] result;
        fflags_t     fflags;
        logic        has_fflags;
    } fpu_lane_out_t;

    typedef struct packed {
        logic                                valid;
        fpu_meta_t                           meta;
        logic [`FPU_NUM_THREADS-1:0][31:0]   data;
    } fpu_commit_t;

    typedef struct packed {
        logic                    enable;
        logic [`FPU_NW_BITS-1:0] wid;
        fflags_t                 fflags;
    } fpu_csr_wr_t;

endpackage

// ==== logic/fpu_req_queue.sv ====
`timescale 1ns/1ps
`include "fpu_consts.svh"

module fpu_req_queue (
    input  logic                clk,
    input  logic                reset,
    input  fpu_pkg::fpu_req_t   req,
    input  logic                advance,
    output fpu_pkg::fpu_req_t   issue,
    output fpu_pkg::fpu_meta_t  lane_meta
);

    fpu_pkg::fpu_req_t mem [`FPU_QUEUE_SIZE];

    logic [`FPU_QUEUE_BITS-1:0] wr_ptr;
    logic [`FPU_QUEUE_BITS-1:0] rd_ptr;
    logic [`FPU_QUEUE_BITS:0]   count;

    fpu_pkg::fpu_req_t head;
    logic              head_valid;
    logic              push;
    logic              pop;

    fpu_pkg::fpu_meta_t meta_s1;
    fpu_pkg::fpu_meta_t meta_s2;

    // An empty queue lets the incoming request straight through
    always_comb begin
        head_valid = (count != '0) || req.valid;
        head       = (count != '0) ? mem[rd_ptr] : req;
    end

    assign push = req.valid;
    assign pop  = advance && head_valid;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Issue register, held while the pipeline stalls
    always_ff @(posedge clk) begin
        if (reset) begin
            issue.valid <= 1'b0;
        end else if (advance) begin
            issue.valid <= head_valid;
        end
        if (advance) begin
            issue.op   <= head.op;
            issue.meta <= head.meta;
            issue.a    <= head.a;
            issue.b    <= head.b;
            issue.c    <= head.c;
        end
    end

    // Metadata follows the two lane stages
    always_ff @(posedge clk) begin
        if (advance) begin
            meta_s1 <= issue.meta;
            meta_s2 <= meta_s1;
        end
    end

    assign lane_meta = meta_s2;

endmodule

// ==== logic/fpu_lane.sv ====
`timescale 1ns/1ps

module fpu_lane (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   advance,
    input  logic                   valid,
    input  fpu_pkg::fpu_op_e       op,
    input  fpu_pkg::float_word_u   a,
    input  fpu_pkg::float_word_u   b,
    output fpu_pkg::fpu_lane_out_t lane_out
);

    localparam logic [31:0] CANON_NAN = 32'h7fc0_0000;

    // FCLASS bit order, bit 8 is signaling NaN and bit 9 quiet NaN
    function automatic logic [9:0] classify(input fpu_pkg::float_word_u w);
        logic exp_ones;
        logic exp_zero;
        logic frac_zero;
        logic inf;
        logic norm;
        logic sub;
        logic zero;
        logic s;
        exp_ones  = &w.f.exp;
        exp_zero  = ~|w.f.exp;
        frac_zero = ~|w.f.frac;
        s         = w.f.sign;
        inf       = exp_ones & frac_zero;
        norm      = ~exp_ones & ~exp_zero;
        sub       = exp_zero & ~frac_zero;
        zero      = exp_zero & frac_zero;
        classify  = {exp_ones & w.f.frac[22],
                     exp_ones & ~frac_zero & ~w.f.frac[22],
                     ~s & inf, ~s & norm, ~s & sub, ~s & zero,
                     s & zero, s & sub, s & norm, s & inf};
    endfunction

    logic                 s1_valid;
    fpu_pkg::fpu_op_e     s1_op;
    fpu_pkg::float_word_u s1_a;
    fpu_pkg::float_word_u s1_b;
    logic [9:0]           s1_cls_a;
    logic [9:0]           s1_cls_b;

    logic             a_nan;
    logic             b_nan;
    logic             a_snan;
    logic             b_snan;
    logic             both_zero;
    logic             lt_total;
    logic             lt_cmp;
    logic             eq_cmp;
    logic [31:0]      result;
    fpu_pkg::fflags_t flags;
    logic             has_flags;

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
        end else if (advance) begin
            s1_valid <= valid;
        end
        if (advance) begin
            s1_op    <= op;
            s1_a     <= a;
            s1_b     <= b;
            s1_cls_a <= classify(a);
            s1_cls_b <= classify(b);
        end
    end

    always_comb begin
        a_snan    = s1_cls_a[8];
        b_snan    = s1_cls_b[8];
        a_nan     = s1_cls_a[8] | s1_cls_a[9];
        b_nan     = s1_cls_b[8] | s1_cls_b[9];
        both_zero = (s1_cls_a[3] | s1_cls_a[4]) & (s1_cls_b[3] | s1_cls_b[4]);

        // Total order where -0 sorts below +0
        if (s1_a.f.sign != s1_b.f.sign) begin
            lt_total = s1_a.f.sign;
        end else if (s1_a.f.sign) begin
            lt_total = s1_b.raw[30:0] < s1_a.raw[30:0];
        end else begin
            lt_total = s1_a.raw[30:0] < s1_b.raw[30:0];
        end

        eq_cmp = ~a_nan & ~b_nan & ((s1_a.raw == s1_b.raw) | both_zero);
        lt_cmp = ~a_nan & ~b_nan & lt_total & ~both_zero;

        result    = '0;
        flags     = '0;
        has_flags = 1'b0;
        case (s1_op)
            fpu_pkg::FPU_SGNJ:  result = {s1_b.f.sign, s1_a.raw[30:0]};
            fpu_pkg::FPU_SGNJN: result = {~s1_b.f.sign, s1_a.raw[30:0]};
            fpu_pkg::FPU_SGNJX: result = {s1_a.f.sign ^ s1_b.f.sign, s1_a.raw[30:0]};
            fpu_pkg::FPU_MIN, fpu_pkg::FPU_MAX: begin
                has_flags = 1'b1;
                flags.nv  = a_snan | b_snan;
                if (a_nan && b_nan) begin
                    result = CANON_NAN;
                end else if (a_nan) begin
                    result = s1_b.raw;
                end else if (b_nan) begin
                    result = s1_a.raw;
                end else if (lt_total ^ (s1_op == fpu_pkg::FPU_MAX)) begin
                    result = s1_a.raw;
                end else begin
                    result = s1_b.raw;
                end
            end
            fpu_pkg::FPU_EQ: begin
                has_flags = 1'b1;
                flags.nv  = a_snan | b_snan;
                result    = {31'b0, eq_cmp};
            end
            fpu_pkg::FPU_LT: begin
                has_flags = 1'b1;
                flags.nv  = a_nan | b_nan;
                result    = {31'b0, lt_cmp};
            end
            fpu_pkg::FPU_LE: begin
                has_flags = 1'b1;
                flags.nv  = a_nan | b_nan;
                result    = {31'b0, lt_cmp | eq_cmp};
            end
            fpu_pkg::FPU_CLASS: result = {22'b0, s1_cls_a};
            default:            result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lane_out.valid <= 1'b0;
        end else if (advance) begin
            lane_out.valid <= s1_valid;
        end
        if (advance) begin
            lane_out.result     <= result;
            lane_out.fflags     <= flags;
            lane_out.has_fflags <= has_flags;
        end
    end

endmodule

// ==== logic/fpu_commit.sv ====
`timescale 1ns/1ps
`include "fpu_consts.svh"

module fpu_commit (
    input  logic                                           clk,
    input  logic                                           reset,
    input  fpu_pkg::fpu_lane_out_t [`FPU_NUM_THREADS-1:0]  lane_out,
    input  fpu_pkg::fpu_meta_t                             lane_meta,
    // Valid bit above the warp id of the incoming request
    input  logic [`FPU_NW_BITS:0]                          accept,
    input  logic                                           commit_credit,
    output logic                                           advance,
    output fpu_pkg::fpu_commit_t                           commit,
    output fpu_pkg::fpu_csr_wr_t                           csr_wr,
    output logic                                           req_credit,
    output logic [`FPU_NUM_WARPS-1:0]                      pending
);

    localparam int CREDIT_BITS = $clog2(`FPU_COMMIT_CREDITS + 1);

    logic [CREDIT_BITS-1:0] credits;
    logic                   s2_valid;
    logic                   fire;
    fpu_pkg::fflags_t       merged;

    assign s2_valid = lane_out[0].valid;
    assign advance  = (credits != '0) || !s2_valid;
    assign fire     = advance && s2_valid;

    // Only active threads contribute flags
    always_comb begin
        merged = '0;
        for (int i = 0; i < `FPU_NUM_THREADS; i++) begin
            if (lane_meta.tmask[i]) begin
                merged = merged | lane_out[i].fflags;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            credits <= CREDIT_BITS'(`FPU_COMMIT_CREDITS);
        end else begin
            credits <= credits - CREDIT_BITS'(fire) + CREDIT_BITS'(commit_credit);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            commit.valid  <= 1'b0;
            csr_wr.enable <= 1'b0;
        end else begin
            commit.valid  <= fire;
            csr_wr.enable <= fire && lane_out[0].has_fflags;
        end
        if (fire) begin
            commit.meta   <= lane_meta;
            csr_wr.wid    <= lane_meta.wid;
            csr_wr.fflags <= merged;
            for (int i = 0; i < `FPU_NUM_THREADS; i++) begin
                commit.data[i] <= lane_out[i].result;
            end
        end
    end

    // The issuer's slot frees once its commit leaves
    assign req_credit = commit.valid;

    // A same-cycle accept wins over the clear
    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= '0;
        end else begin
            if (commit.valid) begin
                pending[commit.meta.wid] <= 1'b0;
            end
            if (accept[`FPU_NW_BITS]) begin
                pending[accept[`FPU_NW_BITS-1:0]] <= 1'b1;
            end
        end
    end

endmodule

// ==== logic/fpu_unit.sv ====
`timescale 1ns/1ps
`include "fpu_consts.svh"

module fpu_unit (
    input  logic                          clk,
    input  logic                          reset,
    input  fpu_pkg::fpu_req_t             req,
    output logic                          req_credit,
    output fpu_pkg::fpu_commit_t          commit,
    input  logic                          commit_credit,
    output fpu_pkg::fpu_csr_wr_t          csr_wr,
    output logic [`FPU_NUM_WARPS-1:0]     pending
);

    fpu_pkg::fpu_req_t                             issue;
    fpu_pkg::fpu_meta_t                            lane_meta;
    fpu_pkg::fpu_lane_out_t [`FPU_NUM_THREADS-1:0] lane_out;
    logic                                          advance;

    fpu_req_queue u_queue (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .advance   (advance),
        .issue     (issue),
        .lane_meta (lane_meta)
    );

    // Operand c rides along in the request but no kept op reads it
    for (genvar i = 0; i < `FPU_NUM_THREADS; i++) begin : g_lane
        fpu_lane u_lane (
            .clk      (clk),
            .reset    (reset),
            .advance  (advance),
            .valid    (issue.valid),
            .op       (issue.op),
            .a        (issue.a[i]),
            .b        (issue.b[i]),
            .lane_out (lane_out[i])
        );
    end

    fpu_commit u_commit (
        .clk           (clk),
        .reset         (reset),
        .lane_out      (lane_out),
        .lane_meta     (lane_meta),
        .accept        ({req.valid, req.meta.wid}),
        .commit_credit (commit_credit),
        .advance       (advance),
        .commit        (commit),
        .csr_wr        (csr_wr),
        .req_credit    (req_credit),
        .pending       (pending)
    );

endmodule

// ==== tests/fpu_tb.sv ====
`timescale 1ns/1ps
`include "fpu_consts.svh"

module fpu_tb;

    localparam int NUM_REQS   = 300;
    localparam int CLK_PERIOD = 40;

    // Signaling and quiet NaNs, infinities, zeros, subnormals and a few normals
    localparam logic [31:0] SPECIAL [16] = '{
        32'h7f80_0001, 32'h7fa0_0000, 32'hffc0_0000, 32'h7fc0_0000,
        32'h7f80_0000, 32'hff80_0000, 32'h0000_0000, 32'h8000_0000,
        32'h0000_0001, 32'h807f_ffff, 32'h3f80_0000, 32'hbf80_0000,
        32'h0040_0000, 32'h7f7f_ffff, 32'hff7f_ffff, 32'h7fff_ffff
    };

    logic                      clk = 1'b0;
    logic                      reset;
    fpu_pkg::fpu_req_t         req;
    logic                      req_credit;
    fpu_pkg::fpu_commit_t      commit;
    logic                      commit_credit;
    fpu_pkg::fpu_csr_wr_t      csr_wr;
    logic [`FPU_NUM_WARPS-1:0] pending;

    logic [31:0]               rand_state = 32'h330f0e10;
    logic [`FPU_NUM_WARPS-1:0] pend_model = '0;
    fpu_pkg::fpu_commit_t      exp_commit_q [$];
    fpu_pkg::fpu_csr_wr_t      exp_csr_q [$];
    int req_credits  = `FPU_QUEUE_SIZE;
    int owed         = 0;
    int sent         = 0;
    int cycle        = 0;
    int n_req_credit = 0;
    int n_commits    = 0;

    fpu_unit u_dut (
        .clk           (clk),
        .reset         (reset),
        .req           (req),
        .req_credit    (req_credit),
        .commit        (commit),
        .commit_credit (commit_credit),
        .csr_wr        (csr_wr),
        .pending       (pending)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    function automatic logic [31:0] pick_operand();
        logic [31:0] x;
        x = next_rand();
        return (x[31:30] == 2'b00) ? next_rand() : SPECIAL[x[19:16]];
    endfunction

    function automatic logic is_nan(input logic [31:0] w);
        return (w[30:23] == 8'hff) && (w[22:0] != '0);
    endfunction

    // Unsigned order over non-NaN words, -0 below +0
    function automatic logic [31:0] order_key(input logic [31:0] w);
        return w[31] ? ~w : (w | 32'h8000_0000);
    endfunction

    function automatic logic [31:0] class_mask(input logic [31:0] w);
        int idx;
        if (is_nan(w))
            idx = w[22] ? 9 : 8;
        else if (w[30:23] == 8'hff)
            idx = w[31] ? 0 : 7;
        else if (w[30:23] != 8'h00)
            idx = w[31] ? 1 : 6;
        else if (w[22:0] != '0)
            idx = w[31] ? 2 : 5;
        else
            idx = w[31] ? 3 : 4;
        return 32'(1) << idx;
    endfunction

    function automatic fpu_pkg::fpu_lane_out_t ref_lane(input fpu_pkg::fpu_op_e op,
                                                       input logic [31:0] a,
                                                       input logic [31:0] b);
        fpu_pkg::fpu_lane_out_t r;
        logic a_nan, b_nan, any_snan, zeros, lt, eq;
        r         = '0;
        r.valid   = 1'b1;
        a_nan     = is_nan(a);
        b_nan     = is_nan(b);
        any_snan  = (a_nan && !a[22]) || (b_nan && !b[22]);
        zeros     = (a[30:0] == '0) && (b[30:0] == '0);
        eq        = !a_nan && !b_nan && ((a == b) || zeros);
        lt        = !a_nan && !b_nan && !zeros && (order_key(a) < order_key(b));
        case (op)
            fpu_pkg::FPU_SGNJ:  r.result = {b[31], a[30:0]};
            fpu_pkg::FPU_SGNJN: r.result = {~b[31], a[30:0]};
            fpu_pkg::FPU_SGNJX: r.result = {a[31] ^ b[31], a[30:0]};
            fpu_pkg::FPU_MIN, fpu_pkg::FPU_MAX: begin
                r.has_fflags = 1'b1;
                r.fflags.nv  = any_snan;
                if (a_nan && b_nan)
                    r.result = 32'h7fc0_0000;
                else if (a_nan)
                    r.result = b;
                else if (b_nan)
                    r.result = a;
                else if ((order_key(a) < order_key(b)) == (op == fpu_pkg::FPU_MIN))
                    r.result = a;
                else
                    r.result = b;
            end
            fpu_pkg::FPU_EQ, fpu_pkg::FPU_LT, fpu_pkg::FPU_LE: begin
                r.has_fflags = 1'b1;
                r.fflags.nv  = (op == fpu_pkg::FPU_EQ) ? any_snan : (a_nan || b_nan);
                if (op == fpu_pkg::FPU_EQ)
                    r.result = {31'b0, eq};
                else if (op == fpu_pkg::FPU_LT)
                    r.result = {31'b0, lt};
                else
                    r.result = {31'b0, lt || eq};
            end
            default: r.result = class_mask(a);
        endcase
        return r;
    endfunction

    task automatic report_failure(input string msg);
        $display("** Error @ %0t: %s", $time, msg);
        $display("** FAIL **");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic check_commit(input fpu_pkg::fpu_commit_t got,
                                input fpu_pkg::fpu_commit_t want);
        int i;
        if (got.meta !== want.meta)
            report_failure($sformatf("commit meta %h, expected %h", got.meta, want.meta));
        for (i = 0; i < `FPU_NUM_THREADS; i++) begin
            if (want.meta.tmask[i] && (got.data[i] !== want.data[i]))
                report_failure($sformatf("lane %0d result %h, expected %h",
                                         i, got.data[i], want.data[i]));
        end
    endtask

    task automatic check_csr_wr(input fpu_pkg::fpu_csr_wr_t got,
                                input fpu_pkg::fpu_csr_wr_t want);
        if (got.enable !== want.enable)
            report_failure($sformatf("csr_wr enable %b, expected %b", got.enable, want.enable));
        else if (want.enable && ((got.wid !== want.wid) || (got.fflags !== want.fflags)))
            report_failure($sformatf("csr_wr wid %0d flags %b, expected wid %0d flags %b",
                                     got.wid, got.fflags, want.wid, want.fflags));
    endtask

    task automatic check_pending(input logic [`FPU_NUM_WARPS-1:0] got,
                                 input logic [`FPU_NUM_WARPS-1:0] want);
        if (got !== want)
            report_failure($sformatf("pending %b, expected %b", got, want));
    endtask

    task automatic make_request(output fpu_pkg::fpu_req_t r);
        fpu_pkg::fpu_commit_t   ec;
        fpu_pkg::fpu_csr_wr_t   ew;
        fpu_pkg::fpu_lane_out_t lo;
        logic [31:0]            x;
        int                     i;
        r             = '0;
        r.valid       = 1'b1;
        x             = next_rand();
        r.op          = fpu_pkg::fpu_op_e'(4'(x[31:16] % 16'd9));
        r.meta.wid    = `FPU_NW_BITS'(x >> 4);
        r.meta.tmask  = `FPU_NUM_THREADS'(x >> 8);
        r.meta.rd     = `FPU_NR_BITS'(x >> 10);
        r.meta.wb     = x[0];
        x             = next_rand();
        r.meta.pc     = {x[31:2], 2'b00};
        ec            = '0;
        ec.valid      = 1'b1;
        ec.meta       = r.meta;
        ew            = '0;
        ew.wid        = r.meta.wid;
        for (i = 0; i < `FPU_NUM_THREADS; i++) begin
            r.a[i]     = pick_operand();
            r.b[i]     = pick_operand();
            r.c[i]     = next_rand();
            lo         = ref_lane(r.op, r.a[i].raw, r.b[i].raw);
            ec.data[i] = lo.result;
            ew.enable  = lo.has_fflags;
            if (r.meta.tmask[i])
                ew.fflags = ew.fflags | lo.fflags;
        end
        exp_commit_q.push_back(ec);
        exp_csr_q.push_back(ew);
    endtask

    // One falling edge: track credits and the pending model, then drive inputs
    task automatic drive_cycle(input logic may_send);
        fpu_pkg::fpu_req_t         r;
        logic [`FPU_NUM_WARPS-1:0] pend_next;
        logic [31:0]               x;
        @(negedge clk);
        check_pending(pending, pend_model);
        if (req_credit) begin
            req_credits++;
            n_req_credit++;
        end
        if (commit.valid)
            owed++;
        if (owed > `FPU_COMMIT_CREDITS)
            report_failure("commit left while the unit held no commit credit");
        pend_next = pend_model;
        if (commit.valid)
            pend_next[commit.meta.wid] = 1'b0;
        x = next_rand();
        // Credits are held back for 30 of every 100 cycles
        commit_credit = (owed > 0) && (cycle % 100 < 70) && (x[9:8] != 2'b00);
        if (commit_credit)
            owed--;
        req = '0;
        if (may_send && (req_credits > 0) && (sent < NUM_REQS) && (x[5:4] != 2'b00)) begin
            make_request(r);
            req = r;
            req_credits--;
            sent++;
            pend_next[r.meta.wid] = 1'b1;
        end
        pend_model = pend_next;
        cycle++;
    endtask

    // Scoreboard
    initial begin
        fpu_pkg::fpu_commit_t want_c;
        fpu_pkg::fpu_csr_wr_t want_w;
        @(negedge reset);
        forever begin
            @(negedge clk);
            if (req_credit !== commit.valid)
                report_failure("req_credit pulse does not line up with a commit");
            if (commit.valid) begin
                if (exp_commit_q.size() == 0)
                    report_failure("commit arrived with no request outstanding");
                want_c = exp_commit_q.pop_front();
                want_w = exp_csr_q.pop_front();
                check_commit(commit, want_c);
                check_csr_wr(csr_wr, want_w);
                n_commits++;
            end else if (csr_wr.enable !== 1'b0) begin
                report_failure("csr_wr enabled without a commit");
            end
        end
    end

    initial begin
        #(NUM_REQS * 40 * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d clock cycles", NUM_REQS * 40);
        $display("** FAIL **");
        $fatal(1, "watchdog expired");
    end

    initial begin
        reset         = 1'b1;
        req           = '0;
        commit_credit = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        repeat (3) begin
            drive_cycle(1'b0);
            if (commit.valid || csr_wr.enable || req_credit || (pending != '0))
                report_failure("outputs not idle after reset");
        end
        while ((sent < NUM_REQS) || (n_req_credit < NUM_REQS))
            drive_cycle(1'b1);
        repeat (2) drive_cycle(1'b0);
        if ((exp_commit_q.size() == 0) && (n_commits == NUM_REQS)
                && (n_req_credit == NUM_REQS)) begin
            $display("** PASS **");
            $finish;
        end else begin
            report_failure($sformatf("%0d commits and %0d credits for %0d requests",
                                     n_commits, n_req_credit, NUM_REQS));
        end
    end

endmodule

// ==== tb.f ====
+incdir+logic
logic/fpu_pkg.sv
logic/fpu_req_queue.sv
logic/fpu_lane.sv
logic/fpu_commit.sv
logic/fpu_unit.sv
tests/fpu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= fpu_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
SEED      ?= 1
VFLAGS    ?= --binary --timing -j 0

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1
	@if grep -q '^\*\* PASS \*\*$$' $(LOG); then \
		echo "Simulation passed, log in $(LOG)"; \
	else \
		echo "Simulation failed, log in $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

.PHONY: sim clean
